// File: debug_settings.svh
`ifndef DEBUG_SETTINGS_SVH
`define DEBUG_SETTINGS_SVH

// Width of one host frame
`define DBG_FRAME_BITS 32

// Width of a controller id on the request bus
`define DBG_REQ_ID_BITS 6

// Fetch stage controllers
`define DBG_ID_FETCH_DATA 6'b100100
`define DBG_ID_FETCH_CTRL 6'b100101

// Decode stage controllers
`define DBG_ID_DECODE_DATA 6'b100110
`define DBG_ID_DECODE_CTRL 6'b100111

// Execute stage controllers
`define DBG_ID_EXEC_DATA 6'b101000
`define DBG_ID_EXEC_CTRL 6'b101001

// Memory stage controllers
`define DBG_ID_MEM_DATA 6'b101010
`define DBG_ID_MEM_CTRL 6'b101011

`endif

// File: debug_pkg.sv
`include "debug_settings.svh"

package debug_pkg;

   // One frame on the host side
   typedef logic [`DBG_FRAME_BITS-1:0] frame_t;

   // Controller id carried by a read request
   typedef logic [`DBG_REQ_ID_BITS-1:0] req_id_t;

   // Host command opcodes
   typedef enum logic [1:0] {
      CMD_NOP   = 2'd0,
      CMD_READ  = 2'd1,
      CMD_RESET = 2'd2
   } cmd_op_t;

   // Host command word, op in the top two bits
   typedef struct packed {
      cmd_op_t op;
      req_id_t id;
   } debug_cmd_t;

endpackage

// File: stage_pkg.sv
package stage_pkg;

   // Fetch stage, instruction register only
   typedef struct packed {
      logic [31:0] ir;
   } fetch_data_t;

   typedef struct packed {
      logic [31:0] system_pc;
      logic [31:0] pc_plus4;
   } fetch_ctrl_t;

   // Decode stage operands, 5 + 32 + 32 + 16 bits
   typedef struct packed {
      logic [4:0]  shamt;
      logic [31:0] a;
      logic [31:0] b;
      logic [15:0] imm;
   } decode_data_t;

   // Ex is alu op plus three selects
   typedef struct packed {
      logic [6:0]  ex_ctrl;
      logic [4:0]  mem_ctrl;
      logic [7:0]  wb_ctrl;
      logic [31:0] pc;
   } decode_ctrl_t;

   typedef struct packed {
      logic [31:0] alu_result;
      logic [31:0] b;
   } exec_data_t;

   typedef struct packed {
      logic [4:0]  mem_ctrl;
      logic [7:0]  wb_ctrl;
      logic [31:0] pc;
   } exec_ctrl_t;

   // Memory stage results
   typedef struct packed {
      logic [31:0] reg_wb;
      logic [31:0] load_value;
   } mem_data_t;

   typedef struct packed {
      logic [7:0]  wb_ctrl;
      logic [31:0] pc;
   } mem_ctrl_t;

   // Full snapshot, fetch data in the top bits
   typedef struct packed {
      fetch_data_t  fetch_data;
      fetch_ctrl_t  fetch_ctrl;
      decode_data_t decode_data;
      decode_ctrl_t decode_ctrl;
      exec_data_t   exec_data;
      exec_ctrl_t   exec_ctrl;
      mem_data_t    mem_data;
      mem_ctrl_t    mem_ctrl;
   } pipeline_snapshot_t;

endpackage

// File: debug_stage_latch.sv
`timescale 1ns/100ps

module debug_stage_latch #(
   parameter type                payload_t = logic [31:0],
   parameter debug_pkg::req_id_t ID        = '0
) (
   input  logic               i_clock,
   input  logic               reset,
   input  logic               i_soft_reset,
   input  logic               i_req_valid,
   input  debug_pkg::req_id_t i_req_id,
   input  payload_t           i_payload,
   output debug_pkg::frame_t  o_frame,
   output logic               o_frame_valid,
   output logic               o_writing
);

   localparam int PAYLOAD_BITS = $bits(payload_t);
   localparam int FRAME_BITS   = $bits(debug_pkg::frame_t);
   localparam int N_FRAMES     = (PAYLOAD_BITS + FRAME_BITS - 1) / FRAME_BITS;
   localparam int SHIFT_BITS   = N_FRAMES * FRAME_BITS;
   localparam int CNT_BITS     = $clog2(N_FRAMES + 1);

   logic [SHIFT_BITS-1:0] shift_q;
   logic [CNT_BITS-1:0]   count_q;
   logic                  busy;
   logic                  req_hit;

   // Frames left to send
   assign busy = (count_q != '0);

   assign req_hit = i_req_valid && (i_req_id == ID) && !busy;

   always_ff @(posedge i_clock) begin
      if (reset || i_soft_reset) begin
         count_q <= '0;
      end else if (req_hit) begin
         count_q <= CNT_BITS'(N_FRAMES);
      end else if (busy) begin
         count_q <= count_q - 1'b1;
      end
   end

   // Zero padded on the MSB side, shifted up one frame per cycle
   always_ff @(posedge i_clock) begin
      if (req_hit) begin
         shift_q <= SHIFT_BITS'(i_payload);
      end else if (busy) begin
         shift_q <= shift_q << FRAME_BITS;
      end
   end

   assign o_frame       = shift_q[SHIFT_BITS-1 -: FRAME_BITS];
   assign o_frame_valid = busy;
   assign o_writing     = busy;

endmodule

// File: debug_host_link.sv
`timescale 1ns/100ps

module debug_host_link (
   input  logic                    i_clock,
   input  logic                    reset,
   input  logic                    i_cmd_valid,
   input  debug_pkg::debug_cmd_t   i_cmd,
   input  debug_pkg::frame_t [7:0] i_frames,
   input  logic [7:0]              i_frame_valid,
   input  logic [7:0]              i_writing,
   output logic                    o_req_valid,
   output debug_pkg::req_id_t      o_req_id,
   output logic                    o_soft_reset,
   output debug_pkg::frame_t       o_frame,
   output logic                    o_frame_valid,
   output logic                    o_end_of_data
);

   logic              any_writing;
   logic              busy;
   logic              read_cmd;
   logic              reset_cmd;
   logic              clear;
   logic              writing_d;
   debug_pkg::frame_t frame_mux;

   assign any_writing = |i_writing;

   // A request in flight counts as busy until the latch picks it up
   assign busy = any_writing || o_req_valid;

   assign read_cmd  = i_cmd_valid && (i_cmd.op == debug_pkg::CMD_READ) && !busy;
   assign reset_cmd = i_cmd_valid && (i_cmd.op == debug_pkg::CMD_RESET);

   assign clear = reset || o_soft_reset;

   always_ff @(posedge i_clock) begin
      if (reset) begin
         o_soft_reset <= 1'b0;
      end else begin
         o_soft_reset <= reset_cmd;
      end
   end

   always_ff @(posedge i_clock) begin
      if (clear) begin
         o_req_valid <= 1'b0;
      end else begin
         o_req_valid <= read_cmd;
      end
   end

   // Id goes out unchecked, the latches decide
   always_ff @(posedge i_clock) begin
      if (read_cmd) begin
         o_req_id <= i_cmd.id;
      end
   end

   // One-hot AND-OR mux over the latch frames
   always_comb begin
      frame_mux = '0;
      for (int i = 0; i < 8; i++) begin
         if (i_frame_valid[i]) begin
            frame_mux = frame_mux | i_frames[i];
         end
      end
   end

   always_ff @(posedge i_clock) begin
      o_frame <= frame_mux;
   end

   // End of data lines up one cycle after the last registered frame
   always_ff @(posedge i_clock) begin
      if (clear) begin
         o_frame_valid <= 1'b0;
         writing_d     <= 1'b0;
         o_end_of_data <= 1'b0;
      end else begin
         o_frame_valid <= |i_frame_valid;
         writing_d     <= any_writing;
         o_end_of_data <= writing_d && !any_writing;
      end
   end

endmodule

// File: debug_readout.sv
`timescale 1ns/100ps
`include "debug_settings.svh"

module debug_readout (
   input  logic                          i_clock,
   input  logic                          reset,
   input  logic                          i_cmd_valid,
   input  debug_pkg::debug_cmd_t         i_cmd,
   input  stage_pkg::pipeline_snapshot_t i_snapshot,
   output debug_pkg::frame_t             o_frame,
   output logic                          o_frame_valid,
   output logic                          o_end_of_data
);

   debug_pkg::frame_t [7:0] latch_frames;
   logic [7:0]              latch_frame_valid;
   logic [7:0]              latch_writing;
   logic                    req_valid;
   debug_pkg::req_id_t      req_id;
   logic                    soft_reset;

   debug_host_link link0 (
      .i_clock       (i_clock),
      .reset         (reset),
      .i_cmd_valid   (i_cmd_valid),
      .i_cmd         (i_cmd),
      .i_frames      (latch_frames),
      .i_frame_valid (latch_frame_valid),
      .i_writing     (latch_writing),
      .o_req_valid   (req_valid),
      .o_req_id      (req_id),
      .o_soft_reset  (soft_reset),
      .o_frame       (o_frame),
      .o_frame_valid (o_frame_valid),
      .o_end_of_data (o_end_of_data)
   );

   // Fetch
   debug_stage_latch #(
      .payload_t (stage_pkg::fetch_data_t),
      .ID        (`DBG_ID_FETCH_DATA)
   ) fetch_data_latch0 (
      .i_clock       (i_clock),
      .reset         (reset),
      .i_soft_reset  (soft_reset),
      .i_req_valid   (req_valid),
      .i_req_id      (req_id),
      .i_payload     (i_snapshot.fetch_data),
      .o_frame       (latch_frames[0]),
      .o_frame_valid (latch_frame_valid[0]),
      .o_writing     (latch_writing[0])
   );

   debug_stage_latch #(
      .payload_t (stage_pkg::fetch_ctrl_t),
      .ID        (`DBG_ID_FETCH_CTRL)
   ) fetch_ctrl_latch0 (
      .i_clock       (i_clock),
      .reset         (reset),
      .i_soft_reset  (soft_reset),
      .i_req_valid   (req_valid),
      .i_req_id      (req_id),
      .i_payload     (i_snapshot.fetch_ctrl),
      .o_frame       (latch_frames[1]),
      .o_frame_valid (latch_frame_valid[1]),
      .o_writing     (latch_writing[1])
   );

   // Decode
   debug_stage_latch #(
      .payload_t (stage_pkg::decode_data_t),
      .ID        (`DBG_ID_DECODE_DATA)
   ) decode_data_latch0 (
      .i_clock       (i_clock),
      .reset         (reset),
      .i_soft_reset  (soft_reset),
      .i_req_valid   (req_valid),
      .i_req_id      (req_id),
      .i_payload     (i_snapshot.decode_data),
      .o_frame       (latch_frames[2]),
      .o_frame_valid (latch_frame_valid[2]),
      .o_writing     (latch_writing[2])
   );

   debug_stage_latch #(
      .payload_t (stage_pkg::decode_ctrl_t),
      .ID        (`DBG_ID_DECODE_CTRL)
   ) decode_ctrl_latch0 (
      .i_clock       (i_clock),
      .reset         (reset),
      .i_soft_reset  (soft_reset),
      .i_req_valid   (req_valid),
      .i_req_id      (req_id),
      .i_payload     (i_snapshot.decode_ctrl),
      .o_frame       (latch_frames[3]),
      .o_frame_valid (latch_frame_valid[3]),
      .o_writing     (latch_writing[3])
   );

   // Execute
   debug_stage_latch #(
      .payload_t (stage_pkg::exec_data_t),
      .ID        (`DBG_ID_EXEC_DATA)
   ) exec_data_latch0 (
      .i_clock       (i_clock),
      .reset         (reset),
      .i_soft_reset  (soft_reset),
      .i_req_valid   (req_valid),
      .i_req_id      (req_id),
      .i_payload     (i_snapshot.exec_data),
      .o_frame       (latch_frames[4]),
      .o_frame_valid (latch_frame_valid[4]),
      .o_writing     (latch_writing[4])
   );

   debug_stage_latch #(
      .payload_t (stage_pkg::exec_ctrl_t),
      .ID        (`DBG_ID_EXEC_CTRL)
   ) exec_ctrl_latch0 (
      .i_clock       (i_clock),
      .reset         (reset),
      .i_soft_reset  (soft_reset),
      .i_req_valid   (req_valid),
      .i_req_id      (req_id),
      .i_payload     (i_snapshot.exec_ctrl),
      .o_frame       (latch_frames[5]),
      .o_frame_valid (latch_frame_valid[5]),
      .o_writing     (latch_writing[5])
   );

   // Memory
   debug_stage_latch #(
      .payload_t (stage_pkg::mem_data_t),
      .ID        (`DBG_ID_MEM_DATA)
   ) mem_data_latch0 (
      .i_clock       (i_clock),
      .reset         (reset),
      .i_soft_reset  (soft_reset),
      .i_req_valid   (req_valid),
      .i_req_id      (req_id),
      .i_payload     (i_snapshot.mem_data),
      .o_frame       (latch_frames[6]),
      .o_frame_valid (latch_frame_valid[6]),
      .o_writing     (latch_writing[6])
   );

   debug_stage_latch #(
      .payload_t (stage_pkg::mem_ctrl_t),
      .ID        (`DBG_ID_MEM_CTRL)
   ) mem_ctrl_latch0 (
      .i_clock       (i_clock),
      .reset         (reset),
      .i_soft_reset  (soft_reset),
      .i_req_valid   (req_valid),
      .i_req_id      (req_id),
      .i_payload     (i_snapshot.mem_ctrl),
      .o_frame       (latch_frames[7]),
      .o_frame_valid (latch_frame_valid[7]),
      .o_writing     (latch_writing[7])
   );

endmodule

// File: debug_readout_sva.sv
`timescale 1ns/100ps

module debug_readout_sva (
   input logic       i_clock,
   input logic       reset,
   input logic [7:0] i_writing,
   input logic       o_req_valid,
   input logic       o_frame_valid,
   input logic       o_end_of_data
);

   // Only one latch may drive frames at a time
   a_writing_onehot: assert property (
      @(posedge i_clock) disable iff (reset) $onehot0(i_writing)
   ) else $error("more than one latch writing: %b", i_writing);

   a_frame_or_eod: assert property (
      @(posedge i_clock) disable iff (reset) !(o_frame_valid && o_end_of_data)
   ) else $error("frame valid and end of data high together");

   // End of data follows the last frame directly
   a_eod_after_frame: assert property (
      @(posedge i_clock) disable iff (reset) o_end_of_data |-> $past(o_frame_valid)
   ) else $error("end of data without a frame in the cycle before");

   a_reset_quiet: assert property (
      @(posedge i_clock) reset |=>
         (!o_frame_valid && !o_end_of_data && !o_req_valid && i_writing == 8'h00)
   ) else $error("outputs not cleared after reset");

endmodule

bind debug_host_link debug_readout_sva sva0 (
   .i_clock       (i_clock),
   .reset         (reset),
   .i_writing     (i_writing),
   .o_req_valid   (o_req_valid),
   .o_frame_valid (o_frame_valid),
   .o_end_of_data (o_end_of_data)
);

// File: tb_debug_readout.sv
`timescale 1ns/100ps
`include "debug_settings.svh"

module tb_debug_readout;

   logic                          i_clock = 1'b0;
   logic                          reset;
   logic                          i_cmd_valid;
   debug_pkg::debug_cmd_t         i_cmd;
   stage_pkg::pipeline_snapshot_t i_snapshot;
   debug_pkg::frame_t             o_frame;
   logic                          o_frame_valid;
   logic                          o_end_of_data;

   debug_pkg::req_id_t known_ids [8];
   int errors   = 0;
   int frames   = 0;
   int eod_exp  = 0;
   int eod_seen = 0;

   debug_readout dut0 (
      .i_clock       (i_clock),
      .reset         (reset),
      .i_cmd_valid   (i_cmd_valid),
      .i_cmd         (i_cmd),
      .i_snapshot    (i_snapshot),
      .o_frame       (o_frame),
      .o_frame_valid (o_frame_valid),
      .o_end_of_data (o_end_of_data)
   );

   always #5 i_clock = ~i_clock;

   // Payload width rounded up to whole frames
   function automatic int frame_count(debug_pkg::req_id_t id);
      case (id)
         `DBG_ID_FETCH_DATA:  return 1;
         `DBG_ID_DECODE_DATA: return 3;
         `DBG_ID_FETCH_CTRL, `DBG_ID_DECODE_CTRL, `DBG_ID_EXEC_DATA,
            `DBG_ID_EXEC_CTRL, `DBG_ID_MEM_DATA, `DBG_ID_MEM_CTRL: return 2;
         default: return 0;
      endcase
   endfunction

   // Zero padded word with frame 0 as the most significant
   function automatic debug_pkg::frame_t expected_frame(stage_pkg::pipeline_snapshot_t snap,
                                                        debug_pkg::req_id_t id, int k);
      logic [95:0] padded;
      case (id)
         `DBG_ID_FETCH_DATA:  padded = 96'(snap.fetch_data);
         `DBG_ID_FETCH_CTRL:  padded = 96'(snap.fetch_ctrl);
         `DBG_ID_DECODE_DATA: padded = 96'(snap.decode_data);
         `DBG_ID_DECODE_CTRL: padded = 96'(snap.decode_ctrl);
         `DBG_ID_EXEC_DATA:   padded = 96'(snap.exec_data);
         `DBG_ID_EXEC_CTRL:   padded = 96'(snap.exec_ctrl);
         `DBG_ID_MEM_DATA:    padded = 96'(snap.mem_data);
         `DBG_ID_MEM_CTRL:    padded = 96'(snap.mem_ctrl);
         default:             padded = '0;
      endcase
      return padded[(frame_count(id) - 1 - k) * 32 +: 32];
   endfunction

   function automatic stage_pkg::pipeline_snapshot_t random_snapshot();
      logic [447:0] bits;
      int           i;
      for (i = 0; i < 14; i++) begin
         bits[i*32 +: 32] = $urandom();
      end
      return bits[445:0];
   endfunction

   task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
      if (actual !== expected) begin
         errors++;
         $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
      end
   endtask

   task automatic send_cmd(debug_pkg::cmd_op_t op, debug_pkg::req_id_t id);
      debug_pkg::debug_cmd_t cmd;
      cmd.op = op;
      cmd.id = id;
      @(posedge i_clock);
      i_cmd_valid <= 1'b1;
      i_cmd       <= cmd;
      @(posedge i_clock);
      i_cmd_valid <= 1'b0;
      i_cmd       <= '0;
   endtask

   // Two reads in consecutive cycles
   task automatic send_back_to_back_reads(debug_pkg::req_id_t id0, debug_pkg::req_id_t id1);
      debug_pkg::debug_cmd_t cmd0;
      debug_pkg::debug_cmd_t cmd1;
      cmd0.op = debug_pkg::CMD_READ;
      cmd0.id = id0;
      cmd1.op = debug_pkg::CMD_READ;
      cmd1.id = id1;
      @(posedge i_clock);
      i_cmd_valid <= 1'b1;
      i_cmd       <= cmd0;
      @(posedge i_clock);
      i_cmd       <= cmd1;
      @(posedge i_clock);
      i_cmd_valid <= 1'b0;
      i_cmd       <= '0;
   endtask

   task automatic wait_end_of_data(int limit);
      int n;
      n = 0;
      while (n < limit && o_end_of_data !== 1'b1) begin
         @(negedge i_clock);
         n++;
      end
      if (o_end_of_data !== 1'b1) begin
         errors++;
         $display("Timeout: no end of data within %0d cycles at %0t", limit, $time);
      end
   endtask

   // New snapshot while idle and then one full readout
   task automatic read_word(debug_pkg::req_id_t id);
      @(posedge i_clock);
      i_snapshot <= random_snapshot();
      send_cmd(debug_pkg::CMD_READ, id);
      wait_end_of_data(20);
   endtask

   // Readout model checking the outputs at every falling edge
   initial begin : compare
      int                            cycle;
      int                            busy_until;
      bit                            act_valid;
      bit                            act_eod;
      bit                            exp_fv;
      bit                            exp_eod;
      int                            act_start;
      int                            act_count;
      int                            act_cap;
      debug_pkg::req_id_t            act_id;
      stage_pkg::pipeline_snapshot_t act_snap;
      cycle      = 0;
      busy_until = 0;
      act_valid  = 1'b0;
      forever begin
         @(negedge i_clock);
         cycle++;
         if (reset) begin
            act_valid  = 1'b0;
            busy_until = 0;
         end else begin
            exp_fv  = act_valid && cycle >= act_start && cycle < act_start + act_count;
            exp_eod = act_valid && act_eod && cycle == act_start + act_count;
            check_value("o_frame_valid", 32'(o_frame_valid), 32'(exp_fv));
            check_value("o_end_of_data", 32'(o_end_of_data), 32'(exp_eod));
            if (exp_fv && o_frame_valid) begin
               check_value("o_frame", o_frame, expected_frame(act_snap, act_id, cycle - act_start));
               frames++;
            end
            if (o_end_of_data === 1'b1) begin
               eod_seen++;
            end
            // Latch takes the snapshot one cycle after the command
            if (act_valid && cycle == act_cap) begin
               act_snap = i_snapshot;
            end
            if (act_valid && cycle >= act_start + act_count) begin
               act_valid = 1'b0;
            end
            if (i_cmd_valid && i_cmd.op == debug_pkg::CMD_READ && cycle > busy_until) begin
               if (frame_count(i_cmd.id) > 0) begin
                  act_valid  = 1'b1;
                  act_eod    = 1'b1;
                  act_id     = i_cmd.id;
                  act_cap    = cycle + 1;
                  act_start  = cycle + 3;
                  act_count  = frame_count(i_cmd.id);
                  busy_until = cycle + 3 + act_count;
                  eod_exp++;
               end else begin
                  busy_until = cycle + 1;
               end
            end
            // Soft reset clears everything from two cycles on
            if (i_cmd_valid && i_cmd.op == debug_pkg::CMD_RESET) begin
               if (act_valid && act_eod && act_start + act_count > cycle + 1) begin
                  act_eod = 1'b0;
                  eod_exp--;
               end
               if (act_valid && act_start + act_count > cycle + 2) begin
                  act_count = (cycle + 2 > act_start) ? cycle + 2 - act_start : 0;
               end
               busy_until = cycle + 1;
            end
         end
      end
   end

   initial begin : stimulus
      int i;
      void'($urandom(9048));
      known_ids = '{`DBG_ID_FETCH_DATA, `DBG_ID_FETCH_CTRL, `DBG_ID_DECODE_DATA,
                    `DBG_ID_DECODE_CTRL, `DBG_ID_EXEC_DATA, `DBG_ID_EXEC_CTRL,
                    `DBG_ID_MEM_DATA, `DBG_ID_MEM_CTRL};
      reset       <= 1'b1;
      i_cmd_valid <= 1'b0;
      i_cmd       <= '0;
      i_snapshot  <= '0;
      repeat (2) @(posedge i_clock);
      reset <= 1'b0;
      repeat (2) @(posedge i_clock);

      for (i = 0; i < 8; i++) begin
         read_word(known_ids[i]);
      end

      // Unknown id must stay silent
      send_cmd(debug_pkg::CMD_READ, 6'b000011);
      repeat (20) @(posedge i_clock);

      // Second read lands while the first is still running
      @(posedge i_clock);
      i_snapshot <= random_snapshot();
      send_cmd(debug_pkg::CMD_READ, `DBG_ID_EXEC_DATA);
      send_cmd(debug_pkg::CMD_READ, `DBG_ID_MEM_CTRL);
      wait_end_of_data(20);
      repeat (10) @(posedge i_clock);

      // Second read while the first request is still in flight
      @(posedge i_clock);
      i_snapshot <= random_snapshot();
      send_back_to_back_reads(`DBG_ID_FETCH_CTRL, `DBG_ID_MEM_DATA);
      wait_end_of_data(20);
      repeat (10) @(posedge i_clock);

      // Host reset cuts a decode readout after its first frame
      @(posedge i_clock);
      i_snapshot <= random_snapshot();
      send_cmd(debug_pkg::CMD_READ, `DBG_ID_DECODE_DATA);
      send_cmd(debug_pkg::CMD_RESET, '0);
      repeat (10) @(posedge i_clock);
      read_word(`DBG_ID_DECODE_DATA);

      repeat (200) begin
         read_word(known_ids[$urandom_range(7, 0)]);
      end
      repeat (10) @(posedge i_clock);

      check_value("end of data count", eod_seen, eod_exp);
      $display("Done: %0d errors, %0d frames checked, %0d end of data pulses",
               errors, frames, eod_seen);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// File: filelist.f
+incdir+.
debug_pkg.sv
stage_pkg.sv
debug_stage_latch.sv
debug_host_link.sv
debug_readout.sv
debug_readout_sva.sv
tb_debug_readout.sv

// File: Makefile
# Verilator lint and simulation for the debug readout path

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TB_TOP    ?= tb_debug_readout
RTL_TOP   ?= debug_readout
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
BUILD_FLAGS ?= -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) $(BUILD_FLAGS) --top-module $(TB_TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TB_TOP)

sim: build
	./$(BUILD_DIR)/$(TB_TOP) | tee $(LOG)
	@if grep -q "Simulation PASSED" $(LOG); then \
		echo "sim: pass message found in $(LOG)"; \
	else \
		echo "sim: pass message missing from $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
